// File: cpu_consts.svh
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// datapath sizes
`define WORD_W      32
`define REG_ADDR_W  5
`define REG_NUM     32

// primary opcodes in inst[31:26]
`define OP_SPECIAL  6'b000000
`define OP_ADDI     6'b001000
`define OP_ADDIU    6'b001001
`define OP_SLTI     6'b001010
`define OP_SLTIU    6'b001011
`define OP_ANDI     6'b001100
`define OP_ORI      6'b001101
`define OP_XORI     6'b001110
`define OP_LUI      6'b001111

// function codes under SPECIAL in inst[5:0]
`define FN_SLL      6'b000000
`define FN_SRL      6'b000010
`define FN_SRA      6'b000011
`define FN_SLLV     6'b000100
`define FN_SRLV     6'b000110
`define FN_SRAV     6'b000111
`define FN_ADD      6'b100000
`define FN_ADDU     6'b100001
`define FN_SUB      6'b100010
`define FN_SUBU     6'b100011
`define FN_AND      6'b100100
`define FN_OR       6'b100101
`define FN_XOR      6'b100110
`define FN_NOR      6'b100111
`define FN_SLT      6'b101010
`define FN_SLTU     6'b101011
`endif

// File: cpu_pkg.sv
`include "cpu_consts.svh"

package cpu_pkg;

    typedef logic [`WORD_W-1:0]     word_t;
    typedef logic [`REG_ADDR_W-1:0] reg_addr_t;

    // add and sub trap on signed overflow, addu and subu wrap
    typedef enum logic [3:0] {
        alu_nop,
        alu_or,
        alu_and,
        alu_xor,
        alu_nor,
        alu_sll,
        alu_srl,
        alu_sra,
        alu_slt,
        alu_sltu,
        alu_add,
        alu_addu,
        alu_sub,
        alu_subu
    } alu_op_e;

endpackage

// File: regfile_rd_if.sv
`timescale 1ns/1ps

interface regfile_rd_if;
    import cpu_pkg::*;

    logic      re1;
    reg_addr_t addr1;
    logic      re2;
    reg_addr_t addr2;
    word_t     data1;
    word_t     data2;

    modport decode  (output re1, addr1, re2, addr2);
    modport regfile (input re1, addr1, re2, addr2, output data1, data2);
    modport operand (input re1, addr1, re2, addr2, data1, data2);

endinterface

// File: id_ex_if.sv
`timescale 1ns/1ps

// decoded instruction from decode into the execute register
interface id_ex_if;
    import cpu_pkg::*;

    logic      valid;   // one cycle per legal instruction
    alu_op_e   op;
    word_t     op1;
    word_t     op2;
    reg_addr_t wd;      // destination register
    logic      wreg;

    // decode drives the control fields, operand select the data fields
    modport src (
        output valid, op, op1, op2, wd, wreg
    );
    modport dst (
        input valid, op, op1, op2, wd, wreg
    );

endinterface

// File: fwd_if.sv
`timescale 1ns/1ps

interface fwd_if;
    import cpu_pkg::*;

    logic      ex_we;
    reg_addr_t ex_addr;
    word_t     ex_data;     // alu output before the memory register
    logic      mem_we;
    reg_addr_t mem_addr;
    word_t     mem_data;

    modport src (output ex_we, ex_addr, ex_data, mem_we, mem_addr, mem_data);
    modport dst (input ex_we, ex_addr, ex_data, mem_we, mem_addr, mem_data);

endinterface

// File: id_decode.sv
`timescale 1ns/1ps
`include "cpu_consts.svh"

module id_decode (
    input  logic           inst_valid_i,
    input  logic [31:0]    inst_i,
    regfile_rd_if.decode   rd_o,
    id_ex_if.src           ie_o,
    output cpu_pkg::word_t imm_o,
    output logic           illegal_o
);
    import cpu_pkg::*;

    logic [5:0] opcode;
    logic [5:0] funct;
    logic [4:0] shamt;
    reg_addr_t  rs;
    reg_addr_t  rt;
    reg_addr_t  rd;
    word_t      imm_zext;
    word_t      imm_sext;
    word_t      imm_upper;
    word_t      imm_shamt;

    alu_op_e    op;
    logic       legal;
    logic       re1;
    logic       re2;
    reg_addr_t  wd;
    word_t      imm;

    assign opcode = inst_i[31:26];
    assign rs     = inst_i[25:21];
    assign rt     = inst_i[20:16];
    assign rd     = inst_i[15:11];
    assign shamt  = inst_i[10:6];
    assign funct  = inst_i[5:0];

    assign imm_zext  = {16'h0, inst_i[15:0]};
    assign imm_sext  = {{16{inst_i[15]}}, inst_i[15:0]};
    assign imm_upper = {inst_i[15:0], 16'h0};
    assign imm_shamt = {27'h0, shamt};

    always_comb begin
        op    = alu_nop;
        legal = 1'b1;
        re1   = 1'b1;
        re2   = 1'b0;
        wd    = rt;     // i-type writes rt
        imm   = '0;
        case (opcode)
            `OP_SPECIAL: begin
                re2 = 1'b1;
                wd  = rd;
                case (funct)
                    `FN_OR:   op = alu_or;
                    `FN_AND:  op = alu_and;
                    `FN_XOR:  op = alu_xor;
                    `FN_NOR:  op = alu_nor;
                    `FN_SLLV: op = alu_sll;
                    `FN_SRLV: op = alu_srl;
                    `FN_SRAV: op = alu_sra;
                    `FN_ADD:  op = alu_add;
                    `FN_ADDU: op = alu_addu;
                    `FN_SUB:  op = alu_sub;
                    `FN_SUBU: op = alu_subu;
                    `FN_SLT:  op = alu_slt;
                    `FN_SLTU: op = alu_sltu;
                    `FN_SLL, `FN_SRL, `FN_SRA: begin
                        re1 = 1'b0;     // shift amount from the shamt field
                        imm = imm_shamt;
                        op  = (funct == `FN_SLL) ? alu_sll :
                              (funct == `FN_SRL) ? alu_srl : alu_sra;
                    end
                    default:  legal = 1'b0;
                endcase
            end
            `OP_ORI:   begin op = alu_or;   imm = imm_zext; end
            `OP_ANDI:  begin op = alu_and;  imm = imm_zext; end
            `OP_XORI:  begin op = alu_xor;  imm = imm_zext; end
            `OP_ADDI:  begin op = alu_add;  imm = imm_sext; end
            `OP_ADDIU: begin op = alu_addu; imm = imm_sext; end
            `OP_SLTI:  begin op = alu_slt;  imm = imm_sext; end
            `OP_SLTIU: begin op = alu_sltu; imm = imm_sext; end
            `OP_LUI: begin
                // both operands take the immediate, or-ing gives it back
                op  = alu_or;
                re1 = 1'b0;
                imm = imm_upper;
            end
            default: legal = 1'b0;
        endcase
        if (!legal) begin
            op  = alu_nop;
            re1 = 1'b0;
            re2 = 1'b0;
        end
    end

    assign rd_o.re1   = re1;
    assign rd_o.addr1 = rs;
    assign rd_o.re2   = re2;
    assign rd_o.addr2 = rt;

    assign ie_o.valid = inst_valid_i & legal;
    assign ie_o.op    = op;
    assign ie_o.wd    = wd;
    assign ie_o.wreg  = legal;
    assign imm_o      = imm;
    assign illegal_o  = inst_valid_i & ~legal;

endmodule

// File: operand_sel.sv
`timescale 1ns/1ps

module operand_sel (
    regfile_rd_if.operand  rd_i,
    fwd_if.dst             fwd_i,
    input  cpu_pkg::word_t imm_i,
    id_ex_if.src           ie_o
);
    import cpu_pkg::*;

    // execute result wins over memory result, r0 never forwards
    function automatic word_t pick(
        input logic      re,
        input reg_addr_t addr,
        input word_t     rf_data,
        input word_t     imm,
        input logic      ex_we,
        input reg_addr_t ex_addr,
        input word_t     ex_data,
        input logic      mem_we,
        input reg_addr_t mem_addr,
        input word_t     mem_data
    );
        if (!re)
            return imm;
        else if (ex_we && (ex_addr == addr) && (addr != '0))
            return ex_data;
        else if (mem_we && (mem_addr == addr) && (addr != '0))
            return mem_data;
        else
            return rf_data;
    endfunction

    assign ie_o.op1 = pick(rd_i.re1, rd_i.addr1, rd_i.data1, imm_i,
                           fwd_i.ex_we, fwd_i.ex_addr, fwd_i.ex_data,
                           fwd_i.mem_we, fwd_i.mem_addr, fwd_i.mem_data);
    assign ie_o.op2 = pick(rd_i.re2, rd_i.addr2, rd_i.data2, imm_i,
                           fwd_i.ex_we, fwd_i.ex_addr, fwd_i.ex_data,
                           fwd_i.mem_we, fwd_i.mem_addr, fwd_i.mem_data);

endmodule

// File: regfile.sv
`timescale 1ns/1ps
`include "cpu_consts.svh"

module regfile (
    input  logic              clk,
    input  logic              arst_n_i,
    regfile_rd_if.regfile     rd_i,
    input  logic              we_i,
    input  cpu_pkg::reg_addr_t waddr_i,
    input  cpu_pkg::word_t    wdata_i
);
    import cpu_pkg::*;

    word_t regs [`REG_NUM];

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < `REG_NUM; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && (waddr_i != '0)) begin   // r0 stays zero
            regs[waddr_i] <= wdata_i;
        end
    end

    // reads see the value from before this cycle's write
    assign rd_i.data1 = (rd_i.re1 && (rd_i.addr1 != '0)) ? regs[rd_i.addr1] : '0;
    assign rd_i.data2 = (rd_i.re2 && (rd_i.addr2 != '0)) ? regs[rd_i.addr2] : '0;

endmodule

// File: ex_stage.sv
`timescale 1ns/1ps
`include "cpu_consts.svh"

module ex_stage (
    input  logic               clk,
    input  logic               arst_n_i,
    id_ex_if.dst               ie_i,
    input  logic               illegal_i,
    fwd_if.src                 fwd_o,
    output logic               wb_valid_o,
    output cpu_pkg::reg_addr_t wb_addr_o,
    output cpu_pkg::word_t     wb_data_o,
    output logic               exc_o
);
    import cpu_pkg::*;

    localparam int MSB = `WORD_W - 1;

    logic      ex_valid;
    logic      ex_wreg;
    logic      ex_illegal;
    alu_op_e   ex_op;
    reg_addr_t ex_wd;
    word_t     ex_op1;
    word_t     ex_op2;

    word_t     sum;
    word_t     diff;
    word_t     alu_res;
    logic      ovf;
    logic      ex_we;
    logic      ex_exc;

    logic      mem_we;
    logic      mem_exc;
    reg_addr_t mem_addr;
    word_t     mem_data;

    // execute register
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ex_valid   <= 1'b0;
            ex_wreg    <= 1'b0;
            ex_illegal <= 1'b0;
            ex_op      <= alu_nop;
            ex_wd      <= '0;
        end else begin
            ex_valid   <= ie_i.valid;
            ex_wreg    <= ie_i.wreg;
            ex_illegal <= illegal_i;
            ex_op      <= ie_i.op;
            ex_wd      <= ie_i.wd;
        end
    end

    always_ff @(posedge clk) begin
        ex_op1 <= ie_i.op1;
        ex_op2 <= ie_i.op2;
    end

    assign sum  = ex_op1 + ex_op2;
    assign diff = ex_op1 - ex_op2;

    // shift amount in op1[4:0] and shifted value in op2
    always_comb begin
        case (ex_op)
            alu_or:             alu_res = ex_op1 | ex_op2;
            alu_and:            alu_res = ex_op1 & ex_op2;
            alu_xor:            alu_res = ex_op1 ^ ex_op2;
            alu_nor:            alu_res = ~(ex_op1 | ex_op2);
            alu_sll:            alu_res = ex_op2 << ex_op1[4:0];
            alu_srl:            alu_res = ex_op2 >> ex_op1[4:0];
            alu_sra:            alu_res = word_t'($signed(ex_op2) >>> ex_op1[4:0]);
            alu_slt:            alu_res = word_t'($signed(ex_op1) < $signed(ex_op2));
            alu_sltu:           alu_res = word_t'(ex_op1 < ex_op2);
            alu_add, alu_addu:  alu_res = sum;
            alu_sub, alu_subu:  alu_res = diff;
            default:            alu_res = '0;
        endcase
    end

    assign ovf = ((ex_op == alu_add) && (ex_op1[MSB] == ex_op2[MSB]) &&
                  (sum[MSB] != ex_op1[MSB])) ||
                 ((ex_op == alu_sub) && (ex_op1[MSB] != ex_op2[MSB]) &&
                  (diff[MSB] != ex_op1[MSB]));

    assign ex_we  = ex_valid & ex_wreg & ~ovf;      // overflow kills the write
    assign ex_exc = ex_illegal | (ex_valid & ovf);

    // memory register
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            mem_we  <= 1'b0;
            mem_exc <= 1'b0;
        end else begin
            mem_we  <= ex_we;
            mem_exc <= ex_exc;
        end
    end

    always_ff @(posedge clk) begin
        mem_addr <= ex_wd;
        mem_data <= alu_res;
    end

    assign fwd_o.ex_we    = ex_we;
    assign fwd_o.ex_addr  = ex_wd;
    assign fwd_o.ex_data  = alu_res;
    assign fwd_o.mem_we   = mem_we;
    assign fwd_o.mem_addr = mem_addr;
    assign fwd_o.mem_data = mem_data;

    assign wb_valid_o = mem_we;
    assign wb_addr_o  = mem_addr;
    assign wb_data_o  = mem_data;
    assign exc_o      = mem_exc;

endmodule

// File: mips_id_core.sv
`timescale 1ns/1ps

module mips_id_core (
    input  logic               clk,
    input  logic               arst_n_i,
    input  logic               inst_valid_i,
    input  cpu_pkg::word_t     inst_i,
    output logic               wb_valid_o,
    output cpu_pkg::reg_addr_t wb_addr_o,
    output cpu_pkg::word_t     wb_data_o,
    output logic               exc_o
);
    import cpu_pkg::*;

    word_t imm;
    logic  illegal;

    regfile_rd_if u_rd_if ();
    id_ex_if      u_ie_if ();
    fwd_if        u_fwd_if ();

    id_decode u_id_decode (
        .inst_valid_i (inst_valid_i),
        .inst_i       (inst_i),
        .rd_o         (u_rd_if.decode),
        .ie_o         (u_ie_if.src),
        .imm_o        (imm),
        .illegal_o    (illegal)
    );

    operand_sel u_operand_sel (
        .rd_i  (u_rd_if.operand),
        .fwd_i (u_fwd_if.dst),
        .imm_i (imm),
        .ie_o  (u_ie_if.src)
    );

    // write port fed straight from the writeback outputs
    regfile u_regfile (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .rd_i     (u_rd_if.regfile),
        .we_i     (wb_valid_o),
        .waddr_i  (wb_addr_o),
        .wdata_i  (wb_data_o)
    );

    ex_stage u_ex_stage (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .ie_i       (u_ie_if.dst),
        .illegal_i  (illegal),
        .fwd_o      (u_fwd_if.src),
        .wb_valid_o (wb_valid_o),
        .wb_addr_o  (wb_addr_o),
        .wb_data_o  (wb_data_o),
        .exc_o      (exc_o)
    );

endmodule

// File: tb_mips_id_core.sv
`timescale 1ns/1ps
`include "cpu_consts.svh"

module tb_mips_id_core;
    import cpu_pkg::*;

    localparam int N_INST     = 2000;
    localparam int MAX_CYCLES = 3 * N_INST + 50;

    // kept encodings picked by index
    localparam logic [95:0] FN_LIST = {
        `FN_OR, `FN_AND, `FN_XOR, `FN_NOR, `FN_SLL, `FN_SRL, `FN_SRA, `FN_SLLV,
        `FN_SRLV, `FN_SRAV, `FN_ADD, `FN_ADDU, `FN_SUB, `FN_SUBU, `FN_SLT, `FN_SLTU
    };
    localparam logic [47:0] OP_LIST = {
        `OP_ORI, `OP_ANDI, `OP_XORI, `OP_LUI, `OP_ADDI, `OP_ADDIU, `OP_SLTI, `OP_SLTIU
    };

    typedef struct packed {
        logic [31:0] cyc;   // cycle in which the outcome shows
        logic        exc;
        reg_addr_t   addr;
        word_t       data;
    } outcome_t;

    logic      clk;
    logic      arst_n_i;
    logic      inst_valid_i;
    word_t     inst_i;
    logic      wb_valid_o;
    reg_addr_t wb_addr_o;
    word_t     wb_data_o;
    logic      exc_o;

    logic [31:0] lcg_state = 32'hd080_b1ef;
    int          cyc = 0;
    word_t       model_regs [`REG_NUM];
    outcome_t    exp_q [$];
    outcome_t    cur;

    mips_id_core u_dut (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .inst_valid_i (inst_valid_i),
        .inst_i       (inst_i),
        .wb_valid_o   (wb_valid_o),
        .wb_addr_o    (wb_addr_o),
        .wb_data_o    (wb_data_o),
        .exc_o        (exc_o)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (cyc >= MAX_CYCLES) begin
            $display("timeout: test did not finish within %0d cycles", MAX_CYCLES);
            $display(">>> FAIL");
            $fatal(1, "simulation timed out");
        end
    end

    function automatic word_t next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic check_val(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("FAILED at %0t: %s = 0x%08h, expected 0x%08h", $time, name, got, exp);
            $display(">>> FAIL");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    function automatic word_t gen_inst();
        word_t       r;
        int          kind;
        reg_addr_t   rs;
        reg_addr_t   rt;
        reg_addr_t   rd;
        logic [4:0]  sa;
        logic [15:0] imm;
        r   = next_rand();
        rs  = {2'b00, r[31:29]};    // r0..r7 only
        rt  = {2'b00, r[28:26]};
        rd  = {2'b00, r[25:23]};
        sa  = r[22:18];
        r   = next_rand();
        imm = r[31:16];
        r   = next_rand();
        if ((r[31:16] % 100) < 5) begin
            case (r[15:14])
                2'd0:    return {`OP_SPECIAL, rs, rt, rd, sa, 6'b010000};  // mfhi
                2'd1:    return {`OP_SPECIAL, rs, rt, rd, sa, 6'b011000};  // mult
                2'd2:    return {6'b100011, rs, rt, imm};                  // lw
                default: return {6'b000100, rs, rt, imm};                  // beq
            endcase
        end
        r    = next_rand();
        kind = r[31:16] % 24;
        if (kind < 16)
            return {`OP_SPECIAL, rs, rt, rd, sa, FN_LIST[kind*6 +: 6]};
        return {OP_LIST[(kind-16)*6 +: 6], rs, rt, imm};
    endfunction

    // executes one instruction in issue order on the model registers
    function automatic outcome_t model_exec(input word_t inst, input int c);
        outcome_t    o;
        reg_addr_t   rs;
        reg_addr_t   rt;
        reg_addr_t   dest;
        logic [4:0]  sa;
        word_t       a;
        word_t       b;
        word_t       sext;
        word_t       zext;
        word_t       res;
        logic [32:0] wide;
        logic        legal;
        logic        ovf;
        rs    = inst[25:21];
        rt    = inst[20:16];
        sa    = inst[10:6];
        a     = model_regs[rs];
        b     = model_regs[rt];
        sext  = {{16{inst[15]}}, inst[15:0]};
        zext  = {16'h0, inst[15:0]};
        legal = 1'b1;
        ovf   = 1'b0;
        res   = '0;
        wide  = '0;
        dest  = rt;
        if (inst[31:26] == `OP_SPECIAL) begin
            dest = inst[15:11];
            case (inst[5:0])
                `FN_OR:   res = a | b;
                `FN_AND:  res = a & b;
                `FN_XOR:  res = a ^ b;
                `FN_NOR:  res = ~(a | b);
                `FN_SLL:  res = b << sa;
                `FN_SRL:  res = b >> sa;
                `FN_SRA:  res = $signed(b) >>> sa;
                `FN_SLLV: res = b << a[4:0];
                `FN_SRLV: res = b >> a[4:0];
                `FN_SRAV: res = $signed(b) >>> a[4:0];
                `FN_ADD:  wide = {a[31], a} + {b[31], b};
                `FN_ADDU: res = a + b;
                `FN_SUB:  wide = {a[31], a} - {b[31], b};
                `FN_SUBU: res = a - b;
                `FN_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                `FN_SLTU: res = (a < b) ? 32'd1 : 32'd0;
                default:  legal = 1'b0;
            endcase
            if (inst[5:0] == `FN_ADD || inst[5:0] == `FN_SUB) begin
                res = wide[31:0];
                ovf = wide[32] != wide[31];     // sign bits disagree
            end
        end else begin
            case (inst[31:26])
                `OP_ORI:   res = a | zext;
                `OP_ANDI:  res = a & zext;
                `OP_XORI:  res = a ^ zext;
                `OP_LUI:   res = {inst[15:0], 16'h0};
                `OP_ADDI:  wide = {a[31], a} + {sext[31], sext};
                `OP_ADDIU: res = a + sext;
                `OP_SLTI:  res = ($signed(a) < $signed(sext)) ? 32'd1 : 32'd0;
                `OP_SLTIU: res = (a < sext) ? 32'd1 : 32'd0;
                default:   legal = 1'b0;
            endcase
            if (inst[31:26] == `OP_ADDI) begin
                res = wide[31:0];
                ovf = wide[32] != wide[31];
            end
        end
        o.cyc  = c + 2;
        o.exc  = !legal || ovf;
        o.addr = dest;
        o.data = res;
        if (!o.exc && dest != '0)
            model_regs[dest] = res;
        return o;
    endfunction

    // outputs are stable at the falling edge
    always @(negedge clk) begin
        if (exp_q.size() != 0 && exp_q[0].cyc == cyc) begin
            cur = exp_q.pop_front();
            check_val("exc_o", exc_o, cur.exc);
            check_val("wb_valid_o", wb_valid_o, !cur.exc);
            if (!cur.exc) begin
                check_val("wb_addr_o", wb_addr_o, cur.addr);
                check_val("wb_data_o", wb_data_o, cur.data);
            end
        end else begin
            check_val("wb_valid_o", wb_valid_o, 1'b0);  // nothing due this cycle
            check_val("exc_o", exc_o, 1'b0);
        end
    end

    initial begin
        word_t inst;
        word_t r;
        int    gap;
        arst_n_i     = 1'b0;
        inst_valid_i = 1'b0;
        inst_i       = '0;
        for (int i = 0; i < `REG_NUM; i++)
            model_regs[i] = '0;
        repeat (2) @(negedge clk);
        arst_n_i = 1'b1;
        repeat (2) @(negedge clk);
        for (int n = 0; n < N_INST; n++) begin
            inst = gen_inst();
            exp_q.push_back(model_exec(inst, cyc));
            inst_valid_i = 1'b1;
            inst_i       = inst;
            @(negedge clk);
            r   = next_rand();
            gap = r[31:16] % 3;
            if (gap != 0) begin
                inst_valid_i = 1'b0;
                inst_i       = '0;
                repeat (gap) @(negedge clk);
            end
        end
        inst_valid_i = 1'b0;
        inst_i       = '0;
        while (exp_q.size() != 0)
            @(negedge clk);
        repeat (2) @(negedge clk);
        $display(">>> PASS");
        $finish;
    end

endmodule

// File: flist.f
+incdir+.
cpu_pkg.sv
regfile_rd_if.sv
id_ex_if.sv
fwd_if.sv
id_decode.sv
operand_sel.sv
regfile.sv
ex_stage.sv
mips_id_core.sv
tb_mips_id_core.sv
